// ==== Makefile ====
# Verilator flow for the WISC pipeline slice

VERILATOR  ?= verilator
TOP        := wisc_pipe_tb
FILELIST   := wisc_pipe.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# The binary exits non-zero on $$fatal or a failed assertion
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== hw/decode.sv ====
// Decode stage, reads operands, classifies the instruction and fills the decode-to-execute register
`timescale 1ns/1ps
`default_nettype none

module decode (
   input  wire                        clk,
   input  wire                        rst_n,
   input  wire                        instr_valid,
   input  wire wisc_pkg::word_t       instruction,
   input  wire wisc_pkg::word_t       incr_pc,
   input  wire wisc_pkg::reg_write_t  wb_write,
   output wisc_pkg::de_ex_t           de_ex
);

   import wisc_pkg::*;

   // Instruction fields
   opcode_t    opcode;
   logic [1:0] func;
   reg_idx_t   rs;
   reg_idx_t   rt;

   // Operand values from the register file
   word_t r1;
   word_t r2;

   // Next content of the pipeline register
   de_ex_t de_ex_d;

   assign opcode = instruction[15:11];
   assign func   = instruction[1:0];
   assign rs     = instruction[10:8];
   assign rt     = instruction[7:5];

   //////////////////////////////////////////////////
   // Register file
   //////////////////////////////////////////////////

   // Writeback writes here, bypass covers the same-cycle write
   reg_file_bypass u_reg_file (
      .clk      (clk),
      .rst_n    (rst_n),
      .rd_idx1  (rs),
      .rd_idx2  (rt),
      .wr       (wb_write),
      .rd_data1 (r1),
      .rd_data2 (r2)
   );

   //////////////////////////////////////////////////
   // Instruction classification
   //////////////////////////////////////////////////

   always_comb begin
      // Defaults fit the 5-bit immediate forms
      de_ex_d         = '0;
      de_ex_d.valid   = instr_valid;
      de_ex_d.incr_pc = incr_pc;
      de_ex_d.r1      = r1;
      de_ex_d.r2      = r2;
      de_ex_d.rs      = rs;
      de_ex_d.rt      = rt;
      de_ex_d.imm     = {{11{instruction[4]}}, instruction[4:0]};
      de_ex_d.alu_op  = ALU_ADD;
      de_ex_d.dest    = instruction[7:5];

      case (opcode)
         OP_HALT:  de_ex_d.halt = 1'b1;
         OP_NOP:   de_ex_d.reg_wrt = 1'b0;
         OP_ADDI,
         OP_SUBI,
         OP_XORI,
         OP_ANDNI: begin
            // Low opcode bits line up with the ALU op order
            de_ex_d.use_imm = 1'b1;
            de_ex_d.reg_wrt = 1'b1;
            de_ex_d.alu_op  = alu_op_t'({1'b0, opcode[1:0]});
         end
         OP_LBI: begin
            // 8-bit immediate, destination in the rs slot
            de_ex_d.imm     = {{8{instruction[7]}}, instruction[7:0]};
            de_ex_d.use_imm = 1'b1;
            de_ex_d.reg_wrt = 1'b1;
            de_ex_d.alu_op  = ALU_PASS_B;
            de_ex_d.dest    = instruction[10:8];
         end
         OP_RTYPE: begin
            de_ex_d.reg_wrt = 1'b1;
            de_ex_d.dest    = instruction[4:2];
            case (func)
               FUNC_ADD:  de_ex_d.alu_op = ALU_ADD;
               FUNC_SUB:  de_ex_d.alu_op = ALU_SUB;
               FUNC_XOR:  de_ex_d.alu_op = ALU_XOR;
               FUNC_ANDN: de_ex_d.alu_op = ALU_ANDN;
               default:   de_ex_d.alu_op = ALU_ADD;
            endcase
         end
         // Anything else is unsupported
         default:  de_ex_d.err = 1'b1;
      endcase

      // Bubble carries no control
      if (!instr_valid) begin
         de_ex_d.reg_wrt = 1'b0;
         de_ex_d.halt    = 1'b0;
         de_ex_d.err     = 1'b0;
      end
   end

   //////////////////////////////////////////////////
   // Decode to execute register
   //////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         de_ex <= '0;
      end else begin
         de_ex <= de_ex_d;
      end
   end

endmodule

`default_nettype wire

// ==== hw/execute.sv ====
// Execute stage, forwards the writeback result and runs the integer ALU
`timescale 1ns/1ps
`default_nettype none

module execute (
   input  wire wisc_pkg::de_ex_t      de_ex,
   input  wire wisc_pkg::reg_write_t  wb_write,
   output wisc_pkg::ex_wb_t           ex_res
);

   import wisc_pkg::*;

   // Forwarding hits per source register
   logic fwd_a;
   logic fwd_b;

   // Register value of rt after forwarding
   word_t rt_val;

   // ALU operands and result
   word_t op_a;
   word_t op_b;
   word_t result;

   //////////////////////////////////////////////////
   // Forwarding
   //////////////////////////////////////////////////

   // Writeback holds the one-older instruction
   assign fwd_a = wb_write.en && (wb_write.idx == de_ex.rs);
   assign fwd_b = wb_write.en && (wb_write.idx == de_ex.rt);

   // Operand A is always rs
   always_comb begin
      op_a = de_ex.r1;
      if (fwd_a) begin
         op_a = wb_write.data;
      end
   end

   // rt value before the immediate mux
   always_comb begin
      rt_val = de_ex.r2;
      if (fwd_b) begin
         rt_val = wb_write.data;
      end
   end

   // Immediate forms replace operand B
   assign op_b = de_ex.use_imm ? de_ex.imm : rt_val;

   //////////////////////////////////////////////////
   // ALU
   //////////////////////////////////////////////////

   // All results wrap at 16 bits
   always_comb begin
      case (de_ex.alu_op)
         ALU_ADD: begin
            result = op_a + op_b;
         end
         ALU_SUB: begin
            // Subtract convention of the ISA, B minus A
            result = op_b - op_a;
         end
         ALU_XOR: begin
            result = op_a ^ op_b;
         end
         ALU_ANDN: begin
            result = op_a & ~op_b;
         end
         ALU_PASS_B: begin
            // LBI
            result = op_b;
         end
         default: begin
            result = op_b;
         end
      endcase
   end

   //////////////////////////////////////////////////
   // Result to writeback
   //////////////////////////////////////////////////

   // Control and PC pass straight through
   always_comb begin
      ex_res.valid   = de_ex.valid;
      ex_res.incr_pc = de_ex.incr_pc;
      ex_res.dest    = de_ex.dest;
      ex_res.result  = result;
      ex_res.reg_wrt = de_ex.reg_wrt;
      ex_res.halt    = de_ex.halt;
      ex_res.err     = de_ex.err;
   end

endmodule

`default_nettype wire

// ==== hw/reg_file_bypass.sv ====
// Eight-entry register file, two read ports and one write port with write-to-read bypass
`timescale 1ns/1ps
`default_nettype none

module reg_file_bypass (
   input  wire                        clk,
   input  wire                        rst_n,
   input  wire wisc_pkg::reg_idx_t    rd_idx1,
   input  wire wisc_pkg::reg_idx_t    rd_idx2,
   input  wire wisc_pkg::reg_write_t  wr,
   output wisc_pkg::word_t            rd_data1,
   output wisc_pkg::word_t            rd_data2
);

   import wisc_pkg::*;

   // Register array, register 0 is ordinary storage
   word_t regs [NUM_REGS];

   // Bypass hits for each read port
   logic hit1;
   logic hit2;

   //////////////////////////////////////////////////
   // Write port
   //////////////////////////////////////////////////

   // All registers come up as zero
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wr.en) begin
         regs[wr.idx] <= wr.data;
      end
   end

   //////////////////////////////////////////////////
   // Read ports
   //////////////////////////////////////////////////

   // Same-cycle write to the index being read
   assign hit1 = wr.en && (wr.idx == rd_idx1);
   assign hit2 = wr.en && (wr.idx == rd_idx2);

   // Write data wins over the stored value
   assign rd_data1 = hit1 ? wr.data : regs[rd_idx1];
   assign rd_data2 = hit2 ? wr.data : regs[rd_idx2];

endmodule

`default_nettype wire

// ==== hw/wisc_pipe_top.sv ====
// Three-stage WISC pipeline slice, decode, execute and writeback
`timescale 1ns/1ps
`default_nettype none

module wisc_pipe_top (
   input  wire                      clk,
   input  wire                      rst_n,
   input  wire                      instr_valid,
   input  wire wisc_pkg::word_t     instruction,
   input  wire wisc_pkg::word_t     incr_pc,
   output logic                     retire_valid,
   output wisc_pkg::word_t          retire_pc,
   output wisc_pkg::reg_idx_t       retire_dest,
   output wisc_pkg::word_t          retire_data,
   output logic                     retire_wrt,
   output logic                     retire_err,
   output logic                     halted
);

   import wisc_pkg::*;

   // Stage links
   de_ex_t     de_ex;
   ex_wb_t     ex_res;
   // Writeback feeds both the register file and forwarding
   reg_write_t wb_write;

   decode u_decode (
      .clk         (clk),
      .rst_n       (rst_n),
      .instr_valid (instr_valid),
      .instruction (instruction),
      .incr_pc     (incr_pc),
      .wb_write    (wb_write),
      .de_ex       (de_ex)
   );

   execute u_execute (
      .de_ex    (de_ex),
      .wb_write (wb_write),
      .ex_res   (ex_res)
   );

   writeback u_writeback (
      .clk          (clk),
      .rst_n        (rst_n),
      .ex_res       (ex_res),
      .wb_write     (wb_write),
      .retire_valid (retire_valid),
      .retire_pc    (retire_pc),
      .retire_dest  (retire_dest),
      .retire_data  (retire_data),
      .retire_wrt   (retire_wrt),
      .retire_err   (retire_err),
      .halted       (halted)
   );

endmodule

`default_nettype wire

// ==== hw/wisc_pkg.sv ====
// WISC pipeline package with data widths, ISA encodings and stage-to-stage structs
`default_nettype none

package wisc_pkg;

   //////////////////////////////////////////////////
   // Widths
   //////////////////////////////////////////////////

   // One data word, also used for instructions and PCs
   typedef logic [15:0] word_t;

   // Register number
   typedef logic [2:0] reg_idx_t;

   // Opcode field, instruction bits 15 to 11
   typedef logic [4:0] opcode_t;

   // Register file depth
   localparam int NUM_REGS = 8;

   //////////////////////////////////////////////////
   // ISA encodings
   //////////////////////////////////////////////////

   // Supported opcodes
   localparam opcode_t OP_HALT  = 5'b00000;
   localparam opcode_t OP_NOP   = 5'b00001;
   localparam opcode_t OP_ADDI  = 5'b01000;
   localparam opcode_t OP_SUBI  = 5'b01001;
   localparam opcode_t OP_XORI  = 5'b01010;
   localparam opcode_t OP_ANDNI = 5'b01011;
   localparam opcode_t OP_LBI   = 5'b11000;
   localparam opcode_t OP_RTYPE = 5'b11011;

   // R-format function field, instruction bits 1 to 0
   localparam logic [1:0] FUNC_ADD  = 2'b00;
   localparam logic [1:0] FUNC_SUB  = 2'b01;
   localparam logic [1:0] FUNC_XOR  = 2'b10;
   localparam logic [1:0] FUNC_ANDN = 2'b11;

   // ALU operation picked in decode
   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_XOR,
      ALU_ANDN,
      ALU_PASS_B
   } alu_op_t;

   //////////////////////////////////////////////////
   // Pipeline structs
   //////////////////////////////////////////////////

   // Register file write, also the forwarding source
   typedef struct packed {
      logic     en;
      reg_idx_t idx;
      word_t    data;
   } reg_write_t;

   // Decode to execute
   typedef struct packed {
      logic     valid;
      word_t    incr_pc;
      word_t    r1;
      word_t    r2;
      reg_idx_t rs;
      reg_idx_t rt;
      word_t    imm;
      logic     use_imm;
      alu_op_t  alu_op;
      logic     reg_wrt;
      reg_idx_t dest;
      logic     halt;
      logic     err;
   } de_ex_t;

   // Execute to writeback
   typedef struct packed {
      logic     valid;
      word_t    incr_pc;
      reg_idx_t dest;
      word_t    result;
      logic     reg_wrt;
      logic     halt;
      logic     err;
   } ex_wb_t;

endpackage

`default_nettype wire

// ==== hw/writeback.sv ====
// Writeback stage, result register, register file write, retire ports and sticky halt
`timescale 1ns/1ps
`default_nettype none

module writeback (
   input  wire                      clk,
   input  wire                      rst_n,
   input  wire wisc_pkg::ex_wb_t    ex_res,
   output wisc_pkg::reg_write_t     wb_write,
   output logic                     retire_valid,
   output wisc_pkg::word_t          retire_pc,
   output wisc_pkg::reg_idx_t       retire_dest,
   output wisc_pkg::word_t          retire_data,
   output logic                     retire_wrt,
   output logic                     retire_err,
   output logic                     halted
);

   import wisc_pkg::*;

   // Result register
   ex_wb_t wb_q;

   // Frozen once halted
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wb_q <= '0;
      end else if (!halted) begin
         wb_q <= ex_res;
      end
   end

   // Sticky halt, set the cycle after HALT retires
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         halted <= 1'b0;
      end else if (retire_valid && wb_q.halt) begin
         halted <= 1'b1;
      end
   end

   // Nothing retires or writes after halt
   assign retire_valid = wb_q.valid & ~halted;
   assign retire_wrt   = retire_valid & wb_q.reg_wrt;
   assign retire_err   = retire_valid & wb_q.err;
   assign retire_pc    = wb_q.incr_pc;
   assign retire_dest  = wb_q.dest;
   assign retire_data  = wb_q.result;

   // Register file write, also forwarded to execute
   always_comb begin
      wb_write.en   = retire_wrt;
      wb_write.idx  = wb_q.dest;
      wb_write.data = wb_q.result;
   end

endmodule

`default_nettype wire

// ==== verification/wisc_pipe_chk.sv ====
// Concurrent assertions on the writeback retire and halt outputs
`timescale 1ns/1ps
`default_nettype none

module wisc_pipe_chk (
   input wire clk,
   input wire rst_n,
   input wire retire_valid,
   input wire retire_wrt,
   input wire halted
);

   //////////////////////////////////////////////////
   // Halt behavior
   //////////////////////////////////////////////////

   // Sticky once set
   a_halt_sticky: assert property (
      @(posedge clk) disable iff (!rst_n) halted |=> halted
   ) else $error("halted fell after it was set");

   // Nothing retires while halted
   a_no_retire_halted: assert property (
      @(posedge clk) disable iff (!rst_n) halted |-> !retire_valid
   ) else $error("retire_valid high while halted");

   //////////////////////////////////////////////////
   // Retire consistency
   //////////////////////////////////////////////////

   // A register write only comes with a retire
   a_wrt_needs_valid: assert property (
      @(posedge clk) disable iff (!rst_n) retire_wrt |-> retire_valid
   ) else $error("retire_wrt high without retire_valid");

endmodule

// Attached to every writeback instance
bind writeback wisc_pipe_chk u_chk (
   .clk          (clk),
   .rst_n        (rst_n),
   .retire_valid (retire_valid),
   .retire_wrt   (retire_wrt),
   .halted       (halted)
);

`default_nettype wire

// ==== verification/wisc_pipe_tb.sv ====
// Table-driven testbench for the three-stage WISC pipeline slice
`timescale 1ns/1ps
`default_nettype none

module wisc_pipe_tb;

   import wisc_pkg::*;

   // One table row with stimulus and expected retire
   typedef struct packed {
      word_t    instr;
      word_t    pc;
      logic     chain;
      logic     retires;
      logic     exp_wrt;
      logic     exp_err;
      logic     check_data;
      reg_idx_t exp_dest;
      word_t    exp_data;
   } entry_t;

   // DUT ports
   logic     clk;
   logic     rst_n;
   logic     instr_valid;
   word_t    instruction;
   word_t    incr_pc;
   logic     retire_valid;
   word_t    retire_pc;
   reg_idx_t retire_dest;
   word_t    retire_data;
   logic     retire_wrt;
   logic     retire_err;
   logic     halted;

   // Table and scoreboard state
   entry_t      tbl[$];
   word_t       next_pc;
   int          num_retire;
   int          sb_idx = 0;
   int          cycle_cnt = 0;
   int          cycle_limit;
   logic [15:0] lfsr_state;

   wisc_pipe_top uut (
      .clk          (clk),
      .rst_n        (rst_n),
      .instr_valid  (instr_valid),
      .instruction  (instruction),
      .incr_pc      (incr_pc),
      .retire_valid (retire_valid),
      .retire_pc    (retire_pc),
      .retire_dest  (retire_dest),
      .retire_data  (retire_data),
      .retire_wrt   (retire_wrt),
      .retire_err   (retire_err),
      .halted       (halted)
   );

   // 40 ns clock
   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   //////////////////////////////////////////////////
   // Helpers
   //////////////////////////////////////////////////

   task automatic abort_run();
      $display("Test failures found");
      $fatal(1, "Simulation stopped on error");
   endtask

   task automatic compare_word(input string name, input word_t actual, input word_t expected);
      if (actual !== expected) begin
         $display("Error at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
         abort_run();
      end
   endtask

   task automatic compare_idx(input string name, input reg_idx_t actual,
                              input reg_idx_t expected);
      if (actual !== expected) begin
         $display("Error at %0d ns: %s expected %0d, got %0d", $time, name, expected, actual);
         abort_run();
      end
   endtask

   task automatic compare_bit(input string name, input logic actual, input logic expected);
      if (actual !== expected) begin
         $display("Error at %0d ns: %s expected %b, got %b", $time, name, expected, actual);
         abort_run();
      end
   endtask

   // Galois LFSR with taps at 16, 14, 13 and 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      logic [15:0] n;
      n = s >> 1;
      if (s[0]) begin
         n = n ^ 16'hB400;
      end
      return n;
   endfunction

   task automatic take_rand_bit(output logic b);
      b = lfsr_state[0];
      lfsr_state = lfsr_next(lfsr_state);
   endtask

   // Instruction encoders
   function automatic word_t enc_imm(input opcode_t op, input reg_idx_t rs, input reg_idx_t rd,
                                     input logic [4:0] imm);
      return {op, rs, rd, imm};
   endfunction

   function automatic word_t enc_lbi(input reg_idx_t rd, input logic [7:0] imm);
      return {OP_LBI, rd, imm};
   endfunction

   function automatic word_t enc_rtype(input reg_idx_t rs, input reg_idx_t rt, input reg_idx_t rd,
                                       input logic [1:0] fn);
      return {OP_RTYPE, rs, rt, rd, fn};
   endfunction

   task automatic add_entry(input word_t instr, input logic chain, input logic retires,
                            input logic wrt, input logic err, input logic chk,
                            input reg_idx_t dest, input word_t data);
      entry_t e;
      e.instr      = instr;
      e.pc         = next_pc;
      e.chain      = chain;
      e.retires    = retires;
      e.exp_wrt    = wrt;
      e.exp_err    = err;
      e.check_data = chk;
      e.exp_dest   = dest;
      e.exp_data   = data;
      tbl.push_back(e);
      next_pc = next_pc + 16'd2;
      if (retires) begin
         num_retire = num_retire + 1;
      end
   endtask

   //////////////////////////////////////////////////
   // Stimulus table
   //////////////////////////////////////////////////

   // Columns are instr, chain, retires, wrt, err, check data, dest and data
   // Chained rows follow the previous row with no idle cycle
   task automatic build_table();
      add_entry(enc_lbi(3'd1, 8'h25), 1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 3'd1, 16'h0025);
      add_entry(enc_lbi(3'd2, 8'hF0), 1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 3'd2, 16'hFFF0);
      // r1 from two slots back comes through the register file bypass
      add_entry(enc_imm(OP_ADDI, 3'd1, 3'd3, 5'h05), 1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 3'd3, 16'h002A);
      // Forwarding chain where SUBI is imm minus rs
      add_entry(enc_imm(OP_SUBI, 3'd3, 3'd4, 5'h1F), 1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 3'd4, 16'hFFD5);
      add_entry(enc_imm(OP_XORI, 3'd4, 3'd5, 5'h0F), 1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 3'd5, 16'hFFDA);
      add_entry(enc_imm(OP_ANDNI, 3'd5, 3'd6, 5'h10), 1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 3'd6, 16'h000A);
      // R-format group with a wrapping ADD
      add_entry(enc_rtype(3'd1, 3'd2, 3'd7, FUNC_ADD), 1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 3'd7, 16'h0015);
      // rt minus rs into r0
      add_entry(enc_rtype(3'd6, 3'd7, 3'd0, FUNC_SUB), 1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 3'd0, 16'h000B);
      add_entry(enc_rtype(3'd0, 3'd3, 3'd1, FUNC_XOR), 1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 3'd1, 16'h0021);
      add_entry(enc_rtype(3'd4, 3'd1, 3'd2, FUNC_ANDN), 1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 3'd2, 16'hFFD4);
      // NOP and then an unsupported opcode
      add_entry({OP_NOP, 11'd0}, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 3'd0, 16'h0000);
      add_entry({5'b10101, 11'd0}, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 3'd0, 16'h0000);
      // Plain register read three or more slots back
      add_entry(enc_rtype(3'd2, 3'd2, 3'd3, FUNC_ADD), 1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 3'd3, 16'hFFA8);
      add_entry(enc_rtype(3'd0, 3'd3, 3'd4, FUNC_SUB), 1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 3'd4, 16'hFF9D);
      // HALT retires and the rest never do
      add_entry({OP_HALT, 11'd0}, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 3'd0, 16'h0000);
      add_entry(enc_lbi(3'd5, 8'h11), 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 3'd0, 16'h0000);
      add_entry(enc_imm(OP_ADDI, 3'd5, 3'd6, 5'h01), 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 3'd0, 16'h0000);
   endtask

   //////////////////////////////////////////////////
   // Scoreboard and timeout
   //////////////////////////////////////////////////

   task automatic check_retire(input entry_t e);
      compare_word("retire_pc", retire_pc, e.pc);
      compare_bit("retire_wrt", retire_wrt, e.exp_wrt);
      compare_bit("retire_err", retire_err, e.exp_err);
      if (e.check_data) begin
         compare_idx("retire_dest", retire_dest, e.exp_dest);
         compare_word("retire_data", retire_data, e.exp_data);
      end
   endtask

   // Each retire matches the next row, which has to be one that retires
   always @(negedge clk) begin
      if (rst_n && retire_valid) begin
         if (sb_idx >= tbl.size()) begin
            $display("A retire arrived with no table entry left");
            abort_run();
         end else if (!tbl[sb_idx].retires) begin
            $display("An instruction fed after HALT retired");
            abort_run();
         end else begin
            check_retire(tbl[sb_idx]);
            sb_idx = sb_idx + 1;
         end
      end
   end

   always @(posedge clk) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt > cycle_limit) begin
         $display("Timeout, not every expected instruction retired");
         abort_run();
      end
   end

   //////////////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////////////

   initial begin
      logic       b0;
      logic       b1;
      logic [1:0] gap;
      rst_n       = 1'b0;
      instr_valid = 1'b0;
      instruction = '0;
      incr_pc     = '0;
      num_retire  = 0;
      next_pc     = 16'h0002;
      lfsr_state  = 16'd53;
      build_table();
      cycle_limit = 4 * tbl.size() + 20;

      repeat (2) @(posedge clk);
      #2;
      rst_n = 1'b1;

      foreach (tbl[i]) begin
         gap = 2'd0;
         if (!tbl[i].chain) begin
            take_rand_bit(b0);
            take_rand_bit(b1);
            gap = {b1, b0};
         end
         // Idle cycles
         repeat (gap) begin
            @(posedge clk);
            #2;
            instr_valid = 1'b0;
            instruction = '0;
         end
         @(posedge clk);
         #2;
         instr_valid = 1'b1;
         instruction = tbl[i].instr;
         incr_pc     = tbl[i].pc;
      end
      @(posedge clk);
      #2;
      instr_valid = 1'b0;
      instruction = '0;

      wait (sb_idx == num_retire);
      // Window in which a retire after HALT would show up
      repeat (4) @(negedge clk);
      compare_bit("halted", halted, 1'b1);
      $display("All tests passed!");
      $finish;
   end

endmodule

`default_nettype wire

// ==== wisc_pipe.f ====
hw/wisc_pkg.sv
hw/reg_file_bypass.sv
hw/decode.sv
hw/execute.sv
hw/writeback.sv
hw/wisc_pipe_top.sv
verification/wisc_pipe_chk.sv
verification/wisc_pipe_tb.sv
